/* include/axil_config.svh */
`ifndef AXIL_CONFIG_SVH
`define AXIL_CONFIG_SVH

// Byte address width carried on the AW and AR channels
`define AXIL_ADDR_BITS 12

// Width of the W and R data buses
// The strobe has one bit for each byte of this width
`define AXIL_DATA_BITS 32

// Number of data words in the responder memory
// With 32-bit words the valid byte addresses end at 255
`define AXIL_MEM_WORDS 64

// Pipeline depth used by the top level unless it is overridden
`define AXIL_REG_STAGES 2

`endif

/* logic/axil_pkg.sv */
`default_nettype none

`include "axil_config.svh"

package axil_pkg;

    // Write address channel payload
    // The prot field is carried end to end but has no effect on the memory
    typedef struct packed {
        logic [`AXIL_ADDR_BITS-1:0] addr;
        logic [2:0]                 prot;
    } axil_aw_t;

    // Write data channel payload, one strobe bit per byte lane
    typedef struct packed {
        logic [`AXIL_DATA_BITS-1:0]   data;
        logic [`AXIL_DATA_BITS/8-1:0] strb;
    } axil_w_t;

    // Response codes used on B and R
    // Only OKAY and SLVERR are ever produced by this subsystem
    typedef enum logic [1:0] {
        AXIL_OKAY   = 2'b00,
        AXIL_SLVERR = 2'b10
    } axil_resp_e;

    // Write response channel payload
    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    // Read address channel payload, same layout as the write address
    typedef struct packed {
        logic [`AXIL_ADDR_BITS-1:0] addr;
        logic [2:0]                 prot;
    } axil_ar_t;

    // Read data channel payload
    typedef struct packed {
        logic [`AXIL_DATA_BITS-1:0] data;
        axil_resp_e                 resp;
    } axil_r_t;

    // Memory responder FSM states
    typedef enum logic [1:0] {
        RS_IDLE,
        RS_WRITE_RESP,
        RS_READ_RESP
    } resp_state_e;

endpackage

`default_nettype wire

/* logic/ready_enable_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module ready_enable_fifo
#(
    parameter int N_DATA_BITS = 32
)
(
    input  wire logic                   clk,
    input  wire logic                   reset,

    input  wire logic                   enable_from_src,
    input  wire logic [N_DATA_BITS-1:0] data_from_src,
    output logic                        ready_to_src,

    output logic                        enable_to_dst,
    output logic [N_DATA_BITS-1:0]      data_to_dst,
    input  wire logic                   ready_from_dst
);

    // Two storage slots used as a tiny circular buffer
    logic [N_DATA_BITS-1:0] data_q [2];
    logic                   wr_ptr;
    logic                   rd_ptr;
    // Number of occupied slots, 0 to 2
    logic [1:0]             count;
    logic                   push;
    logic                   pop;

    // Ready comes only from the registered occupancy, so the source never
    // sees a combinational path back from the destination ready
    assign ready_to_src = (count != 2'd2);
    assign enable_to_dst = (count != 2'd0);
    // Head of the buffer is always presented to the destination
    assign data_to_dst = data_q[rd_ptr];

    assign push = enable_from_src && ready_to_src;
    assign pop = enable_to_dst && ready_from_dst;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
        end
        else
        begin
            if (push)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
            // A simultaneous push and pop leaves the occupancy unchanged
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            data_q[wr_ptr] <= data_from_src;
    end

    // An offered item must stay put until the destination takes it
    assert property (@(posedge clk) disable iff (reset)
        enable_to_dst && !ready_from_dst |=> enable_to_dst && $stable(data_to_dst));

    // When full and stalled the buffer takes no item, so both pointers stay on one slot
    assert property (@(posedge clk) disable iff (reset)
        (count == 2'd2) && !ready_from_dst |=> (count == 2'd2) && (wr_ptr == rd_ptr));

endmodule

`default_nettype wire

/* logic/axil_reg_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_reg_pipe
#(
    parameter int N_REG_STAGES = 1
)
(
    input  wire logic               clk,
    input  wire logic               reset,

    // Master side
    input  wire axil_pkg::axil_aw_t aw,
    input  wire logic               aw_valid,
    output logic                    aw_ready,
    input  wire axil_pkg::axil_w_t  w,
    input  wire logic               w_valid,
    output logic                    w_ready,
    output axil_pkg::axil_b_t       b,
    output logic                    b_valid,
    input  wire logic               b_ready,
    input  wire axil_pkg::axil_ar_t ar,
    input  wire logic               ar_valid,
    output logic                    ar_ready,
    output axil_pkg::axil_r_t       r,
    output logic                    r_valid,
    input  wire logic               r_ready,

    // Slave side
    output axil_pkg::axil_aw_t      s_aw,
    output logic                    s_aw_valid,
    input  wire logic               s_aw_ready,
    output axil_pkg::axil_w_t       s_w,
    output logic                    s_w_valid,
    input  wire logic               s_w_ready,
    input  wire axil_pkg::axil_b_t  s_b,
    input  wire logic               s_b_valid,
    output logic                    s_b_ready,
    output axil_pkg::axil_ar_t      s_ar,
    output logic                    s_ar_valid,
    input  wire logic               s_ar_ready,
    input  wire axil_pkg::axil_r_t  s_r,
    input  wire logic               s_r_valid,
    output logic                    s_r_ready
);

    import axil_pkg::*;

    genvar s;
    generate
        if (N_REG_STAGES == 0)
        begin : wires
            // No stages requested, so every channel passes straight through
            assign s_aw = aw;
            assign s_aw_valid = aw_valid;
            assign aw_ready = s_aw_ready;
            assign s_w = w;
            assign s_w_valid = w_valid;
            assign w_ready = s_w_ready;
            assign b = s_b;
            assign b_valid = s_b_valid;
            assign s_b_ready = b_ready;
            assign s_ar = ar;
            assign s_ar_valid = ar_valid;
            assign ar_ready = s_ar_ready;
            assign r = s_r;
            assign r_valid = s_r_valid;
            assign s_r_ready = r_ready;
        end
        else
        begin : regs
            // Index 0 is the master end of the chain and index N the slave end
            axil_aw_t aw_p [N_REG_STAGES+1];
            axil_w_t  w_p [N_REG_STAGES+1];
            axil_b_t  b_p [N_REG_STAGES+1];
            axil_ar_t ar_p [N_REG_STAGES+1];
            axil_r_t  r_p [N_REG_STAGES+1];
            logic     aw_v [N_REG_STAGES+1];
            logic     w_v [N_REG_STAGES+1];
            logic     b_v [N_REG_STAGES+1];
            logic     ar_v [N_REG_STAGES+1];
            logic     r_v [N_REG_STAGES+1];
            logic     aw_rdy [N_REG_STAGES+1];
            logic     w_rdy [N_REG_STAGES+1];
            logic     b_rdy [N_REG_STAGES+1];
            logic     ar_rdy [N_REG_STAGES+1];
            logic     r_rdy [N_REG_STAGES+1];

            // Tie the two ends of the chain to the module ports
            assign aw_p[0] = aw;
            assign aw_v[0] = aw_valid;
            assign aw_ready = aw_rdy[0];
            assign w_p[0] = w;
            assign w_v[0] = w_valid;
            assign w_ready = w_rdy[0];
            assign b = b_p[0];
            assign b_valid = b_v[0];
            assign b_rdy[0] = b_ready;
            assign ar_p[0] = ar;
            assign ar_v[0] = ar_valid;
            assign ar_ready = ar_rdy[0];
            assign r = r_p[0];
            assign r_valid = r_v[0];
            assign r_rdy[0] = r_ready;

            assign s_aw = aw_p[N_REG_STAGES];
            assign s_aw_valid = aw_v[N_REG_STAGES];
            assign aw_rdy[N_REG_STAGES] = s_aw_ready;
            assign s_w = w_p[N_REG_STAGES];
            assign s_w_valid = w_v[N_REG_STAGES];
            assign w_rdy[N_REG_STAGES] = s_w_ready;
            assign b_p[N_REG_STAGES] = s_b;
            assign b_v[N_REG_STAGES] = s_b_valid;
            assign s_b_ready = b_rdy[N_REG_STAGES];
            assign s_ar = ar_p[N_REG_STAGES];
            assign s_ar_valid = ar_v[N_REG_STAGES];
            assign ar_rdy[N_REG_STAGES] = s_ar_ready;
            assign r_p[N_REG_STAGES] = s_r;
            assign r_v[N_REG_STAGES] = s_r_valid;
            assign s_r_ready = r_rdy[N_REG_STAGES];

            for (s = 1; s <= N_REG_STAGES; s = s + 1)
            begin : p
                // Requests move from index s-1 toward s
                ready_enable_fifo #(.N_DATA_BITS($bits(axil_aw_t))) aw_fifo
                (
                    .clk(clk),
                    .reset(reset),
                    .enable_from_src(aw_v[s-1]),
                    .data_from_src(aw_p[s-1]),
                    .ready_to_src(aw_rdy[s-1]),
                    .enable_to_dst(aw_v[s]),
                    .data_to_dst(aw_p[s]),
                    .ready_from_dst(aw_rdy[s])
                );

                ready_enable_fifo #(.N_DATA_BITS($bits(axil_w_t))) w_fifo
                (
                    .clk(clk),
                    .reset(reset),
                    .enable_from_src(w_v[s-1]),
                    .data_from_src(w_p[s-1]),
                    .ready_to_src(w_rdy[s-1]),
                    .enable_to_dst(w_v[s]),
                    .data_to_dst(w_p[s]),
                    .ready_from_dst(w_rdy[s])
                );

                ready_enable_fifo #(.N_DATA_BITS($bits(axil_ar_t))) ar_fifo
                (
                    .clk(clk),
                    .reset(reset),
                    .enable_from_src(ar_v[s-1]),
                    .data_from_src(ar_p[s-1]),
                    .ready_to_src(ar_rdy[s-1]),
                    .enable_to_dst(ar_v[s]),
                    .data_to_dst(ar_p[s]),
                    .ready_from_dst(ar_rdy[s])
                );

                // Responses travel the other way, from index s back to s-1
                ready_enable_fifo #(.N_DATA_BITS($bits(axil_b_t))) b_fifo
                (
                    .clk(clk),
                    .reset(reset),
                    .enable_from_src(b_v[s]),
                    .data_from_src(b_p[s]),
                    .ready_to_src(b_rdy[s]),
                    .enable_to_dst(b_v[s-1]),
                    .data_to_dst(b_p[s-1]),
                    .ready_from_dst(b_rdy[s-1])
                );

                ready_enable_fifo #(.N_DATA_BITS($bits(axil_r_t))) r_fifo
                (
                    .clk(clk),
                    .reset(reset),
                    .enable_from_src(r_v[s]),
                    .data_from_src(r_p[s]),
                    .ready_to_src(r_rdy[s]),
                    .enable_to_dst(r_v[s-1]),
                    .data_to_dst(r_p[s-1]),
                    .ready_from_dst(r_rdy[s-1])
                );
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* logic/axil_mem_responder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "axil_config.svh"

module axil_mem_responder
(
    input  wire logic               clk,
    input  wire logic               reset,

    input  wire axil_pkg::axil_aw_t aw,
    input  wire logic               aw_valid,
    output logic                    aw_ready,
    input  wire axil_pkg::axil_w_t  w,
    input  wire logic               w_valid,
    output logic                    w_ready,
    output axil_pkg::axil_b_t       b,
    output logic                    b_valid,
    input  wire logic               b_ready,
    input  wire axil_pkg::axil_ar_t ar,
    input  wire logic               ar_valid,
    output logic                    ar_ready,
    output axil_pkg::axil_r_t       r,
    output logic                    r_valid,
    input  wire logic               r_ready
);

    import axil_pkg::*;

    localparam int IDX_BITS = $clog2(`AXIL_MEM_WORDS);
    localparam int STRB_BITS = `AXIL_DATA_BITS / 8;

    resp_state_e                state;
    logic [`AXIL_DATA_BITS-1:0] mem [`AXIL_MEM_WORDS];
    logic                       write_go;
    logic                       read_go;
    logic                       aw_in_range;
    logic                       ar_in_range;
    logic [IDX_BITS-1:0]        aw_idx;
    logic [IDX_BITS-1:0]        ar_idx;

    // A write needs both AW and W, so each ready waits on the other channel
    // Reads are only taken when no complete write is on offer
    assign aw_ready = (state == RS_IDLE) && w_valid;
    assign w_ready = (state == RS_IDLE) && aw_valid;
    assign ar_ready = (state == RS_IDLE) && !(aw_valid && w_valid);

    assign write_go = aw_valid && aw_ready;
    assign read_go = ar_valid && ar_ready;

    // Word index is the byte address divided by four
    assign aw_idx = aw.addr[IDX_BITS+1:2];
    assign ar_idx = ar.addr[IDX_BITS+1:2];
    // Any address past the last word is an error
    assign aw_in_range = (aw.addr[`AXIL_ADDR_BITS-1:2] < `AXIL_MEM_WORDS);
    assign ar_in_range = (ar.addr[`AXIL_ADDR_BITS-1:2] < `AXIL_MEM_WORDS);

    assign b_valid = (state == RS_WRITE_RESP);
    assign r_valid = (state == RS_READ_RESP);

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= RS_IDLE;
        else
        begin
            case (state)
                RS_IDLE:
                begin
                    if (write_go)
                        state <= RS_WRITE_RESP;
                    else if (read_go)
                        state <= RS_READ_RESP;
                end
                RS_WRITE_RESP:
                begin
                    if (b_ready)
                        state <= RS_IDLE;
                end
                RS_READ_RESP:
                begin
                    if (r_ready)
                        state <= RS_IDLE;
                end
                default:
                    state <= RS_IDLE;
            endcase
        end
    end

    // Memory array and response payloads
    always_ff @(posedge clk)
    begin
        if (write_go)
        begin
            // Only lanes with their strobe bit set are written
            if (aw_in_range)
            begin
                for (int i = 0; i < STRB_BITS; i++)
                begin
                    if (w.strb[i])
                        mem[aw_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
            b.resp <= aw_in_range ? AXIL_OKAY : AXIL_SLVERR;
        end

        if (read_go)
        begin
            r.data <= ar_in_range ? mem[ar_idx] : '0;
            r.resp <= ar_in_range ? AXIL_OKAY : AXIL_SLVERR;
        end
    end

    // Nothing new is accepted while a response is waiting for the master
    assert property (@(posedge clk) disable iff (reset)
        (state != RS_IDLE) |-> !(aw_ready || w_ready || ar_ready));

    // Only one transaction is ever outstanding
    assert property (@(posedge clk) disable iff (reset)
        !(b_valid && r_valid));

endmodule

`default_nettype wire

/* logic/axil_mem_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "axil_config.svh"

module axil_mem_top
#(
    parameter int N_REG_STAGES = `AXIL_REG_STAGES
)
(
    input  wire logic               clk,
    input  wire logic               reset,

    input  wire axil_pkg::axil_aw_t aw,
    input  wire logic               aw_valid,
    output logic                    aw_ready,
    input  wire axil_pkg::axil_w_t  w,
    input  wire logic               w_valid,
    output logic                    w_ready,
    output axil_pkg::axil_b_t       b,
    output logic                    b_valid,
    input  wire logic               b_ready,
    input  wire axil_pkg::axil_ar_t ar,
    input  wire logic               ar_valid,
    output logic                    ar_ready,
    output axil_pkg::axil_r_t       r,
    output logic                    r_valid,
    input  wire logic               r_ready
);

    import axil_pkg::*;

    // Channels between the slave end of the pipeline and the memory
    axil_aw_t s_aw;
    axil_w_t  s_w;
    axil_b_t  s_b;
    axil_ar_t s_ar;
    axil_r_t  s_r;
    logic     s_aw_valid;
    logic     s_aw_ready;
    logic     s_w_valid;
    logic     s_w_ready;
    logic     s_b_valid;
    logic     s_b_ready;
    logic     s_ar_valid;
    logic     s_ar_ready;
    logic     s_r_valid;
    logic     s_r_ready;

    axil_reg_pipe #(.N_REG_STAGES(N_REG_STAGES)) pipe
    (
        .clk(clk),
        .reset(reset),
        .aw(aw),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .w(w),
        .w_valid(w_valid),
        .w_ready(w_ready),
        .b(b),
        .b_valid(b_valid),
        .b_ready(b_ready),
        .ar(ar),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .r(r),
        .r_valid(r_valid),
        .r_ready(r_ready),
        .s_aw(s_aw),
        .s_aw_valid(s_aw_valid),
        .s_aw_ready(s_aw_ready),
        .s_w(s_w),
        .s_w_valid(s_w_valid),
        .s_w_ready(s_w_ready),
        .s_b(s_b),
        .s_b_valid(s_b_valid),
        .s_b_ready(s_b_ready),
        .s_ar(s_ar),
        .s_ar_valid(s_ar_valid),
        .s_ar_ready(s_ar_ready),
        .s_r(s_r),
        .s_r_valid(s_r_valid),
        .s_r_ready(s_r_ready)
    );

    // The memory sits on the slave end and answers one request at a time
    axil_mem_responder mem
    (
        .clk(clk),
        .reset(reset),
        .aw(s_aw),
        .aw_valid(s_aw_valid),
        .aw_ready(s_aw_ready),
        .w(s_w),
        .w_valid(s_w_valid),
        .w_ready(s_w_ready),
        .b(s_b),
        .b_valid(s_b_valid),
        .b_ready(s_b_ready),
        .ar(s_ar),
        .ar_valid(s_ar_valid),
        .ar_ready(s_ar_ready),
        .r(s_r),
        .r_valid(s_r_valid),
        .r_ready(s_r_ready)
    );

endmodule

`default_nettype wire

/* test/axil_mem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "axil_config.svh"

module axil_mem_tb;

    import axil_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int MEM_BYTES = `AXIL_MEM_WORDS * 4;
    // Transactions per phase are 128 fill and read-back, 64 strobe, 12 error range,
    // 16 read burst and 24 back-pressure
    localparam int N_TRANS = 244;
    localparam int WATCHDOG_NS = 200 * N_TRANS * CLK_PERIOD;

    logic     clk;
    logic     reset;
    axil_aw_t aw;
    logic     aw_valid;
    logic     aw_ready;
    axil_w_t  w;
    logic     w_valid;
    logic     w_ready;
    axil_b_t  b;
    logic     b_valid;
    logic     b_ready;
    axil_ar_t ar;
    logic     ar_valid;
    logic     ar_ready;
    axil_r_t  r;
    logic     r_valid;
    logic     r_ready;

    integer      seed;
    integer      ready_seed;
    logic [31:0] rnd;
    logic [31:0] ready_rnd;
    logic        backpressure;
    logic [11:0] addr;

    // Reference memory and the expected response FIFOs are kept as circular arrays
    logic [`AXIL_DATA_BITS-1:0] ref_mem [`AXIL_MEM_WORDS];
    axil_resp_e                 exp_b [256];
    logic [`AXIL_DATA_BITS-1:0] exp_r_data [256];
    axil_resp_e                 exp_r_resp [256];
    logic [7:0]                 b_wr_idx;
    logic [7:0]                 b_rd_idx;
    logic [7:0]                 r_wr_idx;
    logic [7:0]                 r_rd_idx;
    int                         req_count;

    axil_mem_top #(.N_REG_STAGES(2)) dut
    (
        .clk(clk),
        .reset(reset),
        .aw(aw),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .w(w),
        .w_valid(w_valid),
        .w_ready(w_ready),
        .b(b),
        .b_valid(b_valid),
        .b_ready(b_ready),
        .ar(ar),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .r(r),
        .r_valid(r_valid),
        .r_ready(r_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Called on a falling edge, returns on the falling edge after both channels took the write
    task automatic send_write(input logic [11:0] a, input logic [31:0] d, input logic [3:0] s);
        logic aw_go;
        logic w_go;
        aw.addr = a;
        aw.prot = 3'b010;
        w.data = d;
        w.strb = s;
        aw_valid = 1'b1;
        w_valid = 1'b1;
        while (aw_valid || w_valid)
        begin
            // Ready comes from registered state, so it is settled at the falling edge
            aw_go = aw_valid && aw_ready;
            w_go = w_valid && w_ready;
            @(negedge clk);
            if (aw_go)
                aw_valid = 1'b0;
            if (w_go)
                w_valid = 1'b0;
        end
    endtask

    task automatic send_read(input logic [11:0] a);
        logic ar_go;
        ar.addr = a;
        ar.prot = 3'b001;
        ar_valid = 1'b1;
        while (ar_valid)
        begin
            ar_go = ar_ready;
            @(negedge clk);
            if (ar_go)
                ar_valid = 1'b0;
        end
    endtask

    // Wait until every accepted request has been answered
    task automatic wait_idle();
        while ((b_rd_idx != b_wr_idx) || (r_rd_idx != r_wr_idx))
            @(negedge clk);
    endtask

    // Model update and expected responses are taken at request acceptance on the top ports
    always @(posedge clk)
    begin
        if (reset)
        begin
            b_wr_idx <= '0;
            b_rd_idx <= '0;
            r_wr_idx <= '0;
            r_rd_idx <= '0;
            req_count <= 0;
        end
        else
        begin
            if (aw_valid && aw_ready)
            begin
                // W is held until the next write, so it still carries this write's data
                if (aw.addr < MEM_BYTES)
                begin
                    for (int k = 0; k < 4; k++)
                    begin
                        if (w.strb[k])
                            ref_mem[aw.addr / 4][8*k +: 8] <= w.data[8*k +: 8];
                    end
                end
                exp_b[b_wr_idx] <= (aw.addr < MEM_BYTES) ? AXIL_OKAY : AXIL_SLVERR;
                b_wr_idx <= b_wr_idx + 8'd1;
            end
            if (ar_valid && ar_ready)
            begin
                exp_r_data[r_wr_idx] <= (ar.addr < MEM_BYTES) ? ref_mem[ar.addr / 4] : '0;
                exp_r_resp[r_wr_idx] <= (ar.addr < MEM_BYTES) ? AXIL_OKAY : AXIL_SLVERR;
                r_wr_idx <= r_wr_idx + 8'd1;
            end
            if ((aw_valid && aw_ready) || (ar_valid && ar_ready))
                req_count <= req_count + 1;
            if (b_valid && b_ready)
                b_rd_idx <= b_rd_idx + 8'd1;
            if (r_valid && r_ready)
                r_rd_idx <= r_rd_idx + 8'd1;
        end
    end

    // No response may appear before the first request went in
    assert property (@(posedge clk) disable iff (reset)
        (req_count == 0) |-> !b_valid && !r_valid)
        else report_error("response valid raised before any request");

    // Write responses arrive in order and only when one is owed
    assert property (@(posedge clk) disable iff (reset)
        b_valid && b_ready |-> (b_rd_idx != b_wr_idx) && (b.resp === exp_b[b_rd_idx]))
        else report_error("write response missing from the expected queue or wrong");

    assert property (@(posedge clk) disable iff (reset)
        r_valid && r_ready |-> (r_rd_idx != r_wr_idx) && (r.resp === exp_r_resp[r_rd_idx])
            && (r.data === exp_r_data[r_rd_idx]))
        else report_error("read response missing from the expected queue or wrong");

    // A stalled response keeps its valid and payload
    assert property (@(posedge clk) disable iff (reset)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else report_error("write response changed while stalled");

    assert property (@(posedge clk) disable iff (reset)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else report_error("read response changed while stalled");

    // Response readies toggle at random only while back-pressure is on
    always @(negedge clk)
    begin
        if (backpressure)
        begin
            ready_rnd = $random(ready_seed);
            b_ready = ready_rnd[0];
            r_ready = ready_rnd[1];
        end
        else
        begin
            b_ready = 1'b1;
            r_ready = 1'b1;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the transactions did not complete within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        seed = 32'h41bd;
        ready_seed = 32'h41bd ^ 32'h5a5a;
        reset = 1'b1;
        aw = '0;
        aw_valid = 1'b0;
        w = '0;
        w_valid = 1'b0;
        ar = '0;
        ar_valid = 1'b0;
        b_ready = 1'b1;
        r_ready = 1'b1;
        backpressure = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        // Idle time with no request lets the reset check run
        repeat (5) @(negedge clk);

        // Fill every word with a full strobe, then read all of it back
        for (int i = 0; i < `AXIL_MEM_WORDS; i++)
        begin
            rnd = $random(seed);
            send_write(12'(i * 4), rnd, 4'hf);
            wait_idle();
        end
        for (int i = 0; i < `AXIL_MEM_WORDS; i++)
        begin
            send_read(12'(i * 4));
            wait_idle();
        end

        // Each partial strobe write at a random byte address is checked by a read-back
        for (int i = 0; i < 32; i++)
        begin
            rnd = $random(seed);
            addr = {4'h0, rnd[7:0]};
            send_write(addr, $random(seed), rnd[11:8]);
            wait_idle();
            send_read(addr);
            wait_idle();
        end

        // An out of range write and read must leave the aliased in-range word intact
        for (int i = 0; i < 4; i++)
        begin
            rnd = $random(seed);
            addr = {(rnd[11:8] == 4'h0) ? 4'h8 : rnd[11:8], rnd[7:0]};
            send_write(addr, $random(seed), 4'hf);
            wait_idle();
            send_read(addr);
            wait_idle();
            send_read({4'h0, addr[7:0]});
            wait_idle();
        end

        // Back to back reads keep several requests inside the pipeline
        for (int i = 0; i < 16; i++)
        begin
            rnd = $random(seed);
            send_read({4'h0, rnd[7:0]});
        end
        wait_idle();

        backpressure <= 1'b1;
        for (int i = 0; i < 8; i++)
        begin
            rnd = $random(seed);
            addr = {4'h0, rnd[7:0]};
            send_write(addr, $random(seed), rnd[11:8]);
            wait_idle();
            send_read(addr);
            send_read({4'h0, rnd[23:16]});
            wait_idle();
        end
        backpressure <= 1'b0;
        repeat (4) @(negedge clk);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
logic/axil_pkg.sv
logic/ready_enable_fifo.sv
logic/axil_reg_pipe.sv
logic/axil_mem_responder.sv
logic/axil_mem_top.sv
test/axil_mem_tb.sv

/* Bender.yml */
package:
  name: axil_mem

export_include_dirs:
  - include

sources:
  - logic/axil_pkg.sv
  - logic/ready_enable_fifo.sv
  - logic/axil_reg_pipe.sv
  - logic/axil_mem_responder.sv
  - logic/axil_mem_top.sv
  - target: test
    files:
      - test/axil_mem_tb.sv
